//--- hdl/qla_pkg.sv
// --------------------
// shared definitions for the motor-channel RTL
// address map fields, register offsets, current widths,
// DAC frame command and safety-check constants
// imported by wildcard in each module header
// --------------------
package qla_pkg;

    // --------------------
    // widths
    localparam int NUM_CHANNELS = 4;           // axes 1..4

    typedef logic [15:0] addr_t;               // register address
    typedef logic [31:0] data_t;               // register data
    typedef logic [15:0] cur_t;                // offset binary, midscale = zero
    typedef logic [3:0]  chan_t;               // addr[7:4]
    typedef logic [NUM_CHANNELS-1:0] mask_t;   // axis n at bit n-1
    typedef logic [NUM_CHANNELS*16-1:0] cur_bus_t;  // axis n at slice n-1

    // --------------------
    // address map
    // region addr[15:12], channel addr[7:4], offset addr[3:0]
    localparam logic [3:0] ADDR_MAIN        = 4'd0;

    localparam logic [3:0] OFF_STATUS       = 4'd0;   // channel 0 only
    localparam logic [3:0] OFF_ADC_DATA     = 4'd0;   // channel 1..4
    localparam logic [3:0] OFF_DAC_CTRL     = 4'd1;
    localparam logic [3:0] OFF_MOTOR_STATUS = 4'd12;

    // --------------------
    // current and safety
    localparam cur_t CUR_MIDSCALE  = 16'h8000;  // zero current
    localparam cur_t SAFETY_MARGIN = 16'h0400;  // slack on top of 2x command
    localparam int   SAFETY_LIMIT  = 8;         // consecutive bad cycles to trip

    // quad DAC: write input register and update output
    localparam logic [3:0] DAC_CMD_WRITE_UPDATE = 4'h3;

    // serializer FSM
    typedef enum logic [1:0] {
        IDLE  = 2'd0,   // waiting for dac_load
        FRAME = 2'd1,   // csel low, shifting 24 bits
        GAP   = 2'd2    // csel high between frames
    } dac_state_t;

endpackage

//--- hdl/rt_write_arbiter.sv
// --------------------
// real-time block write path
// collects four quadlets, then replays them as DAC_CTRL
// writes to axes 1..4 plus one blk strobe for the DAC update
// muxes replay and host traffic onto the shared write bus
// --------------------
`timescale 1ns/1ns

module rt_write_arbiter import qla_pkg::*; (
    input  logic   sysclk,
    input  logic   reset,
    // real-time quadlets
    input  logic   rt_wen,
    input  chan_t  rt_waddr,   // word index 0..3
    input  data_t  rt_wdata,
    // host write bus
    input  logic   reg_wen,
    input  logic   blk_wen,
    input  addr_t  reg_waddr,
    input  data_t  reg_wdata,
    // merged write bus
    output logic   wen,
    output logic   blk,
    output addr_t  waddr,
    output data_t  wdata,
    output logic   rt_busy     // replay owns the bus
);

    data_t       quad [NUM_CHANNELS];  // quadlet buffer
    logic [2:0]  rp_cnt;               // 0..3 reg writes, 4 = blk strobe
    logic        rp_last;
    logic [1:0]  rp_idx;
    chan_t       rp_chan;

    // --------------------
    // quadlet capture, ignored during replay
    always_ff @(posedge sysclk) begin
        if (rt_wen && !rt_busy && (rt_waddr < chan_t'(NUM_CHANNELS))) begin
            quad[rt_waddr[1:0]] <= rt_wdata;
        end
    end

    // replay counter, kicked off by the last word
    always_ff @(posedge sysclk) begin
        if (reset) begin
            rt_busy <= 1'b0;
            rp_cnt  <= 3'd0;
        end else if (rt_busy) begin
            if (rp_last) begin
                rt_busy <= 1'b0;   // blk strobe went out this cycle
                rp_cnt  <= 3'd0;
            end else begin
                rp_cnt <= rp_cnt + 3'd1;
            end
        end else if (rt_wen && (rt_waddr == chan_t'(NUM_CHANNELS - 1))) begin
            rt_busy <= 1'b1;
            rp_cnt  <= 3'd0;
        end
    end

    assign rp_last = (rp_cnt == 3'(NUM_CHANNELS));
    assign rp_idx  = rp_last ? 2'(NUM_CHANNELS - 1) : rp_cnt[1:0];  // blk uses axis 4
    assign rp_chan = chan_t'(rp_idx) + 4'd1;

    // --------------------
    // write bus mux, host strobes dropped while busy
    always_comb begin
        if (rt_busy) begin
            wen   = ~rp_last;
            blk   = rp_last;
            waddr = {ADDR_MAIN, 4'd0, rp_chan, OFF_DAC_CTRL};
            wdata = quad[rp_idx];
        end else begin
            wen   = reg_wen;
            blk   = blk_wen;
            waddr = reg_waddr;
            wdata = reg_wdata;
        end
    end

endmodule

//--- hdl/cur_cmd_regs.sv
// --------------------
// commanded-current registers for axes 1..4
// a write to DAC_CTRL stores the low 16 bits, a blk strobe
// there raises an update request, held until the DAC is idle
// --------------------
`timescale 1ns/1ns

module cur_cmd_regs import qla_pkg::*; (
    input  logic     sysclk,
    input  logic     reset,
    input  logic     wen,
    input  logic     blk,
    input  addr_t    waddr,
    input  data_t    wdata,
    input  logic     dac_busy,
    output cur_bus_t cmd_bus,    // axis n at slice n-1
    output logic     dac_load    // one-cycle start pulse
);

    chan_t  wchan;
    logic   dac_hit;   // main region, channel 1..4, DAC_CTRL
    logic   req;       // pending update
    logic   grant;

    assign wchan   = waddr[7:4];
    assign dac_hit = (waddr[15:12] == ADDR_MAIN) && (wchan != 4'd0) &&
                     (wchan <= chan_t'(NUM_CHANNELS)) && (waddr[3:0] == OFF_DAC_CTRL);

    // hold off while a load is in flight, busy shows up a cycle later
    assign grant = req && !dac_busy && !dac_load;

    // --------------------
    // command storage
    always_ff @(posedge sysclk) begin
        if (reset) begin
            cmd_bus <= {NUM_CHANNELS{CUR_MIDSCALE}};   // zero current on all axes
        end else if (wen && dac_hit) begin
            cmd_bus[(wchan - 4'd1)*16 +: 16] <= wdata[15:0];
        end
    end

    // update request, new strobes win over the grant so none get lost
    always_ff @(posedge sysclk) begin
        if (reset) begin
            req      <= 1'b0;
            dac_load <= 1'b0;
        end else begin
            if (blk && dac_hit)
                req <= 1'b1;
            else if (grant)
                req <= 1'b0;
            dac_load <= grant;
        end
    end

endmodule

//--- hdl/dac_serializer.sv
// --------------------
// quad DAC serializer
// on dac_load latches all four commands and sends one
// 24-bit frame per axis with command, channel and 16 data bits
// two sysclk per bit and the DAC samples on sclk rising
// --------------------
`timescale 1ns/1ns

module dac_serializer import qla_pkg::*; (
    input  logic     sysclk,
    input  logic     reset,
    input  logic     dac_load,
    input  cur_bus_t cmd_bus,
    output logic     sclk,
    output logic     mosi,
    output logic     csel,      // active low frame select
    output logic     dac_busy
);

    dac_state_t   state;
    cur_bus_t     lat;          // snapshot so commands may move meanwhile
    logic [23:0]  shift;        // MSB on mosi
    logic [4:0]   bit_cnt;      // 0..23
    logic [1:0]   chan_cnt;     // axis-1 of the current frame
    logic [1:0]   next_chan;
    logic         phase;        // low in the sclk low half and counts the gap

    function automatic logic [23:0] dac_frame(input logic [1:0] ch, input cur_t val);
        dac_frame = {DAC_CMD_WRITE_UPDATE, 2'b00, ch, val};
    endfunction

    assign next_chan = chan_cnt + 2'd1;
    assign mosi      = shift[23];
    assign dac_busy  = (state != IDLE);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            state    <= IDLE;
            sclk     <= 1'b0;
            csel     <= 1'b1;
            bit_cnt  <= 5'd0;
            chan_cnt <= 2'd0;
            phase    <= 1'b0;
        end else begin
            case (state)
                IDLE: if (dac_load) begin
                    lat      <= cmd_bus;
                    shift    <= dac_frame(2'd0, cmd_bus[15:0]);   // axis 1 first
                    chan_cnt <= 2'd0;
                    bit_cnt  <= 5'd0;
                    phase    <= 1'b0;
                    csel     <= 1'b0;
                    state    <= FRAME;
                end
                FRAME: begin
                    phase <= ~phase;
                    sclk  <= ~phase;        // rising edge mid-bit
                    if (phase) begin
                        if (bit_cnt == 5'd23) begin
                            csel  <= 1'b1;
                            state <= (chan_cnt == 2'(NUM_CHANNELS - 1)) ? IDLE : GAP;
                        end else begin
                            shift   <= {shift[22:0], 1'b0};   // next bit while sclk low
                            bit_cnt <= bit_cnt + 5'd1;
                        end
                    end
                end
                GAP: begin
                    phase <= ~phase;
                    if (phase) begin        // second gap cycle
                        chan_cnt <= next_chan;
                        shift    <= dac_frame(next_chan, lat[next_chan*16 +: 16]);
                        bit_cnt  <= 5'd0;
                        csel     <= 1'b0;
                        state    <= FRAME;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- hdl/safety_check.sv
// --------------------
// overcurrent check for one axis
// trips when |fb| > 2*|cmd| + margin for SAFETY_LIMIT
// consecutive cycles; the trip latches until cleared
// --------------------
`timescale 1ns/1ns

module safety_check import qla_pkg::*; (
    input  logic  sysclk,
    input  logic  reset,
    input  cur_t  cur_fb,
    input  cur_t  cur_cmd,
    input  logic  clear_disable,   // host clear pulse
    output logic  amp_disable
);

    cur_t         fb_mag;       // distance from midscale
    cur_t         cmd_mag;
    logic [17:0]  limit;        // 2*cmd + margin, no overflow
    logic         violate;
    logic [3:0]   viol_cnt;     // consecutive violating cycles

    // --------------------
    // magnitudes around zero current
    assign fb_mag  = (cur_fb >= CUR_MIDSCALE) ? (cur_fb - CUR_MIDSCALE)
                                              : (CUR_MIDSCALE - cur_fb);
    assign cmd_mag = (cur_cmd >= CUR_MIDSCALE) ? (cur_cmd - CUR_MIDSCALE)
                                               : (CUR_MIDSCALE - cur_cmd);

    assign limit   = {1'b0, cmd_mag, 1'b0} + {2'b00, SAFETY_MARGIN};
    assign violate = ({2'b00, fb_mag} > limit);

    // --------------------
    // counter and latch
    always_ff @(posedge sysclk) begin
        if (reset || clear_disable) begin
            viol_cnt    <= 4'd0;   // clear restarts the count too
            amp_disable <= 1'b0;
        end else if (violate) begin
            if (viol_cnt != 4'(SAFETY_LIMIT))
                viol_cnt <= viol_cnt + 4'd1;   // saturate at limit
            if (viol_cnt == 4'(SAFETY_LIMIT - 1))
                amp_disable <= 1'b1;
        end else begin
            viol_cnt <= 4'd0;   // one good cycle breaks the run
        end
    end

endmodule

//--- hdl/board_regs.sv
// --------------------
// channel-0 status register and register read mux
// a write to the status register clears latched amp
// disables, one bit per axis, one cycle later
// reads are combinational from the decoded read address
// --------------------
`timescale 1ns/1ns

module board_regs import qla_pkg::*; (
    input  logic      sysclk,
    input  logic      reset,
    input  logic [3:0] wenid,        // rotary switch, active low
    input  logic      wen,
    input  addr_t     waddr,
    input  data_t     wdata,
    input  addr_t     reg_raddr,
    input  cur_bus_t  cur_fb,
    input  cur_bus_t  cmd_bus,
    input  mask_t     amp_disable,
    output mask_t     clear_disable, // pulses to the safety checks
    output data_t     reg_rdata
);

    logic [3:0] board_id;
    logic       status_wr;
    chan_t      rd_chan;
    logic [3:0] rd_off;
    logic [1:0] rd_ax;               // axis-1 of the read channel
    cur_t       rd_fb;
    cur_t       rd_cmd;

    assign board_id  = ~wenid;
    assign status_wr = wen && (waddr[15:12] == ADDR_MAIN) && (waddr[7:4] == 4'd0) &&
                       (waddr[3:0] == OFF_STATUS);

    // --------------------
    // clear pulses, single cycle
    always_ff @(posedge sysclk) begin
        if (reset)
            clear_disable <= '0;
        else
            clear_disable <= status_wr ? wdata[NUM_CHANNELS-1:0] : '0;
    end

    // --------------------
    // read mux
    assign rd_chan = reg_raddr[7:4];
    assign rd_off  = reg_raddr[3:0];
    assign rd_ax   = rd_chan[1:0] - 2'd1;   // channel 4 wraps to index 3
    assign rd_fb   = cur_fb[rd_ax*16 +: 16];
    assign rd_cmd  = cmd_bus[rd_ax*16 +: 16];

    always_comb begin
        reg_rdata = '0;   // unmapped reads give 0
        if (reg_raddr[15:12] == ADDR_MAIN) begin
            if (rd_chan == 4'd0) begin
                if (rd_off == OFF_STATUS)
                    reg_rdata = {4'd0, board_id, {(24 - NUM_CHANNELS){1'b0}}, amp_disable};
            end else if (rd_chan <= chan_t'(NUM_CHANNELS)) begin
                case (rd_off)
                    OFF_ADC_DATA:     reg_rdata = {16'd0, rd_fb};
                    OFF_DAC_CTRL:     reg_rdata = {16'd0, rd_cmd};
                    OFF_MOTOR_STATUS: reg_rdata = {3'b000, ~amp_disable[rd_ax], 12'd0, rd_cmd};
                    default:          reg_rdata = '0;
                endcase
            end
        end
    end

endmodule

//--- hdl/qla_motor_top.sv
// --------------------
// motor-channel top level
// host and real-time writes share one bus into the command
// registers; commands go out to the quad DAC and feed one
// overcurrent check per axis
// --------------------
`timescale 1ns/1ns

module qla_motor_top import qla_pkg::*; (
    input  logic       sysclk,
    input  logic       reset,
    // host write bus
    input  logic       reg_wen,
    input  logic       blk_wen,
    input  addr_t      reg_waddr,
    input  data_t      reg_wdata,
    // host read bus, combinational
    input  addr_t      reg_raddr,
    output data_t      reg_rdata,
    // real-time block
    input  logic       rt_wen,
    input  chan_t      rt_waddr,
    input  data_t      rt_wdata,
    output logic       rt_busy,
    // feedback and board
    input  cur_bus_t   cur_fb,
    input  logic [3:0] wenid,
    // quad DAC
    output logic       sclk,
    output logic       mosi,
    output logic       csel,
    output mask_t      amp_disable
);

    // merged write bus
    logic     wen;
    logic     blk;
    addr_t    waddr;
    data_t    wdata;

    cur_bus_t cmd_bus;
    logic     dac_load;
    logic     dac_busy;
    mask_t    clear_disable;

    // --------------------
    rt_write_arbiter rt_arb_i (
        .sysclk, .reset,
        .rt_wen, .rt_waddr, .rt_wdata,
        .reg_wen, .blk_wen, .reg_waddr, .reg_wdata,
        .wen, .blk, .waddr, .wdata,
        .rt_busy
    );

    cur_cmd_regs cmd_regs_i (
        .sysclk, .reset,
        .wen, .blk, .waddr, .wdata,
        .dac_busy, .cmd_bus, .dac_load
    );

    dac_serializer dac_i (
        .sysclk, .reset,
        .dac_load, .cmd_bus,
        .sclk, .mosi, .csel, .dac_busy
    );

    board_regs chan0_i (
        .sysclk, .reset, .wenid,
        .wen, .waddr, .wdata,
        .reg_raddr, .cur_fb, .cmd_bus,
        .amp_disable, .clear_disable, .reg_rdata
    );

    // --------------------
    // one safety check per axis
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_safe
        safety_check safe_i (
            .sysclk        (sysclk),
            .reset         (reset),
            .cur_fb        (cur_fb[i*16 +: 16]),
            .cur_cmd       (cmd_bus[i*16 +: 16]),
            .clear_disable (clear_disable[i]),
            .amp_disable   (amp_disable[i])
        );
    end

endmodule

//--- tests/qla_motor_tb.sv
// --------------------
// directed testbench for the motor-channel top level
// host register access, real-time block writes, DAC frames,
// overcurrent trip and clear, feedback read back
// one line per test and a summary line at the end
// --------------------
`timescale 1ns/1ns

module qla_motor_tb import qla_pkg::*; ();

    logic       sysclk;
    logic       reset;
    logic       reg_wen;
    logic       blk_wen;
    addr_t      reg_waddr;
    data_t      reg_wdata;
    addr_t      reg_raddr;
    data_t      reg_rdata;
    logic       rt_wen;
    chan_t      rt_waddr;
    data_t      rt_wdata;
    logic       rt_busy;
    cur_bus_t   cur_fb;
    logic [3:0] wenid;
    logic       sclk;
    logic       mosi;
    logic       csel;
    mask_t      amp_disable;

    int     errors;
    int     tests_run;
    int     test_start;         // error count when the test began
    integer seed = 56;
    cur_t   exp_cmd [NUM_CHANNELS];   // model of the command registers

    qla_motor_top dut_i (.*);

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    // --------------------
    // compare tasks
    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cur(input string name, input cur_t got, input cur_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%04h expected 0x%04h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mask(input string name, input mask_t got, input mask_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%01h expected 0x%01h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%01h expected 0x%01h", name, got, exp);
            errors++;
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("test %0d %-14s %s (%0d errors)", tests_run, name,
                 (errors == test_start) ? "ok" : "failed", errors - test_start);
        test_start = errors;
    endtask

    // --------------------
    // bus helpers
    function automatic addr_t make_addr(input logic [3:0] region, input chan_t chan,
                                        input logic [3:0] off);
        return {region, 4'd0, chan, off};   // region, unused, channel, offset
    endfunction

    function automatic cur_bus_t pack_cmds();
        cur_bus_t bus;
        for (int i = 0; i < NUM_CHANNELS; i++)
            bus[i*16 +: 16] = exp_cmd[i];   // axis n at slice n-1
        return bus;
    endfunction

    task automatic host_write(input addr_t addr, input data_t data, input logic is_blk);
        @(negedge sysclk);
        reg_wen   = ~is_blk;
        blk_wen   = is_blk;
        reg_waddr = addr;
        reg_wdata = data;
        @(negedge sysclk);
        reg_wen = 1'b0;
        blk_wen = 1'b0;
    endtask

    task automatic expect_reg(input string name, input addr_t addr, input data_t exp);
        @(negedge sysclk);
        reg_raddr = addr;
        #2;                     // combinational read settles mid low phase
        check_data(name, reg_rdata, exp);
    endtask

    task automatic wait_csel(input logic level, input int limit);
        int cnt;
        cnt = 0;
        while (csel !== level) begin
            @(negedge sysclk);
            cnt++;
            if (cnt > limit) fail_timeout($sformatf("csel to become %0b", level));
        end
    endtask

    task automatic wait_amp_disable(input int ax, input logic level, input int limit);
        int cnt;
        cnt = 0;
        while (amp_disable[ax] !== level) begin
            @(negedge sysclk);
            cnt++;
            if (cnt > limit) fail_timeout($sformatf("amp_disable[%0d] = %0b", ax, level));
        end
    endtask

    // four frames with mosi sampled on sclk rising while csel is low
    task automatic dac_capture(input cur_bus_t vals);
        logic [23:0] frame;
        logic        prev;
        int          nbits;
        int          cnt;
        for (int f = 0; f < NUM_CHANNELS; f++) begin
            wait_csel(1'b0, 200);
            prev  = sclk;
            nbits = 0;
            cnt   = 0;
            while (nbits < 24) begin
                @(negedge sysclk);
                cnt++;
                if (sclk && !prev) begin
                    frame = {frame[22:0], mosi};   // MSB first
                    nbits++;
                end
                prev = sclk;
                if (cnt > 100) fail_timeout("DAC frame bits");
            end
            check_data($sformatf("dac frame %0d", f), data_t'(frame),
                       data_t'({DAC_CMD_WRITE_UPDATE, 4'(f), vals[f*16 +: 16]}));
            wait_csel(1'b1, 10);
        end
    endtask

    // --------------------
    // tests
    task automatic test_reset_state();
        for (int i = 0; i < NUM_CHANNELS; i++)
            expect_reg($sformatf("dac ctrl %0d", i + 1),
                       make_addr(ADDR_MAIN, chan_t'(i + 1), OFF_DAC_CTRL), {16'd0, CUR_MIDSCALE});
        check_mask("amp_disable", amp_disable, '0);
        check_bit("rt_busy", rt_busy, 1'b0);
        check_bit("csel", csel, 1'b1);
        check_bit("sclk", sclk, 1'b0);
        expect_reg("status", make_addr(ADDR_MAIN, 4'd0, OFF_STATUS), {4'd0, ~wenid, 24'd0});
    endtask

    task automatic test_host_access();
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            exp_cmd[i] = cur_t'(16'h2000 * (i + 1) + 16'h0321);
            host_write(make_addr(ADDR_MAIN, chan_t'(i + 1), OFF_DAC_CTRL),
                       {16'hdead, exp_cmd[i]}, 1'b0);   // upper half ignored
        end
        for (int i = 0; i < NUM_CHANNELS; i++)
            expect_reg($sformatf("dac ctrl %0d", i + 1),
                       make_addr(ADDR_MAIN, chan_t'(i + 1), OFF_DAC_CTRL), {16'd0, exp_cmd[i]});
        host_write(make_addr(ADDR_MAIN, 4'd0, OFF_DAC_CTRL), 32'hffff, 1'b0);
        expect_reg("chan 0 off 1", make_addr(ADDR_MAIN, 4'd0, OFF_DAC_CTRL), '0);
        expect_reg("unused offset", make_addr(ADDR_MAIN, 4'd1, 4'd5), '0);
        expect_reg("other region", make_addr(4'd1, 4'd1, OFF_DAC_CTRL), '0);
        expect_reg("chan 5", make_addr(ADDR_MAIN, 4'd5, OFF_DAC_CTRL), '0);
    endtask

    task automatic test_dac_update();
        cur_bus_t first;
        first = pack_cmds();
        host_write(make_addr(ADDR_MAIN, 4'd1, OFF_DAC_CTRL), '0, 1'b1);
        fork
            dac_capture(first);   // latched copy so later writes must not show
            begin
                wait_csel(1'b0, 20);
                repeat (10) @(negedge sysclk);
                exp_cmd[1] = 16'h9abc;
                host_write(make_addr(ADDR_MAIN, 4'd2, OFF_DAC_CTRL), {16'd0, exp_cmd[1]}, 1'b0);
                host_write(make_addr(ADDR_MAIN, 4'd2, OFF_DAC_CTRL), '0, 1'b1);
            end
        join
        dac_capture(pack_cmds());   // second request waits for the first transfer
    endtask

    task automatic test_rt_block();
        data_t quad [NUM_CHANNELS];
        int    cnt;
        for (int i = 0; i < NUM_CHANNELS; i++)
            quad[i] = $random(seed);
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            @(negedge sysclk);
            rt_wen   = 1'b1;
            rt_waddr = chan_t'(i);
            rt_wdata = quad[i];
        end
        @(negedge sysclk);
        rt_wen = 1'b0;
        check_bit("rt_busy", rt_busy, 1'b1);
        reg_wen   = 1'b1;       // host write during replay is dropped
        reg_waddr = make_addr(ADDR_MAIN, 4'd1, OFF_DAC_CTRL);
        reg_wdata = 32'h1234;
        @(negedge sysclk);
        reg_wen = 1'b0;
        cnt = 0;
        while (rt_busy !== 1'b0) begin
            @(negedge sysclk);
            cnt++;
            if (cnt > 10) fail_timeout("rt_busy to fall");
        end
        for (int i = 0; i < NUM_CHANNELS; i++)
            exp_cmd[i] = quad[i][15:0];
        dac_capture(pack_cmds());
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            @(negedge sysclk);
            reg_raddr = make_addr(ADDR_MAIN, chan_t'(i + 1), OFF_DAC_CTRL);
            #2;
            check_cur($sformatf("rt cmd %0d", i + 1), reg_rdata[15:0], exp_cmd[i]);
        end
    endtask

    task automatic test_safety();
        cur_bus_t fb;
        addr_t    status_addr;
        status_addr = make_addr(ADDR_MAIN, 4'd0, OFF_STATUS);
        exp_cmd[1]  = CUR_MIDSCALE + 16'h0100;   // limit 2*0x100 + 0x400
        host_write(make_addr(ADDR_MAIN, 4'd2, OFF_DAC_CTRL), {16'd0, exp_cmd[1]}, 1'b0);
        fb = {NUM_CHANNELS{CUR_MIDSCALE}};
        fb[16 +: 16] = CUR_MIDSCALE + 16'h2000;    // far over the limit
        cur_fb = fb;
        wait_amp_disable(1, 1'b1, SAFETY_LIMIT + 2);
        check_mask("amp_disable", amp_disable, 4'b0010);
        expect_reg("motor status 2", make_addr(ADDR_MAIN, 4'd2, OFF_MOTOR_STATUS),
                   {16'd0, exp_cmd[1]});
        expect_reg("motor status 1", make_addr(ADDR_MAIN, 4'd1, OFF_MOTOR_STATUS),
                   {3'b000, 1'b1, 12'd0, exp_cmd[0]});
        host_write(status_addr, 32'h2, 1'b0);
        wait_amp_disable(1, 1'b0, 3);
        wait_amp_disable(1, 1'b1, SAFETY_LIMIT + 2);   // violation still there
        check_mask("amp_disable retrip", amp_disable, 4'b0010);
        fb[16 +: 16] = CUR_MIDSCALE + 16'h05ff;    // just inside
        cur_fb = fb;
        host_write(status_addr, 32'h2, 1'b0);
        wait_amp_disable(1, 1'b0, 3);
        repeat (SAFETY_LIMIT + 4) @(negedge sysclk);   // longer than a trip takes
        check_mask("amp_disable in range", amp_disable, '0);
    endtask

    task automatic test_adc_readback();
        cur_bus_t fb;
        for (int i = 0; i < NUM_CHANNELS; i++)
            fb[i*16 +: 16] = cur_t'($random(seed));
        @(negedge sysclk);
        cur_fb = fb;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            @(negedge sysclk);
            reg_raddr = make_addr(ADDR_MAIN, chan_t'(i + 1), OFF_ADC_DATA);
            #2;
            check_cur($sformatf("adc data %0d", i + 1), reg_rdata[15:0], fb[i*16 +: 16]);
        end
    endtask

    // --------------------
    // sequence
    initial begin
        errors     = 0;
        tests_run  = 0;
        test_start = 0;
        reset      = 1'b1;
        reg_wen    = 1'b0;
        blk_wen    = 1'b0;
        reg_waddr  = '0;
        reg_wdata  = '0;
        reg_raddr  = '0;
        rt_wen     = 1'b0;
        rt_waddr   = '0;
        rt_wdata   = '0;
        cur_fb     = {NUM_CHANNELS{CUR_MIDSCALE}};   // zero current everywhere
        wenid      = 4'b1010;
        repeat (4) @(posedge sysclk);
        @(negedge sysclk);
        reset = 1'b0;

        test_reset_state();
        report_test("reset state");
        test_host_access();
        report_test("host access");
        test_dac_update();
        report_test("dac update");
        test_rt_block();
        report_test("rt block");
        test_safety();
        report_test("safety");
        test_adc_readback();
        report_test("adc readback");

        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- qla_motor.f
hdl/qla_pkg.sv
hdl/rt_write_arbiter.sv
hdl/cur_cmd_regs.sv
hdl/dac_serializer.sv
hdl/safety_check.sv
hdl/board_regs.sv
hdl/qla_motor_top.sv
tests/qla_motor_tb.sv

//--- Makefile
# Verilator build and run of the motor-channel testbench

all: run

obj_dir/Vqla_motor_tb: qla_motor.f hdl/*.sv tests/*.sv
	verilator --binary --timing -f qla_motor.f --top-module qla_motor_tb -Mdir obj_dir

run: obj_dir/Vqla_motor_tb
	./obj_dir/Vqla_motor_tb | tee sim.log
	grep -q "=== PASS ===" sim.log

lint:
	verilator --lint-only -Wall --timing -f qla_motor.f --top-module qla_motor_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
